// File: hw/acs_unit.sv
`timescale 1ns/100ps

module acs_unit
    import viterbi_pkg::*;
#(
    parameter int FRAME_LEN = 16
)
(
    input  logic clk,
    input  logic rst,
    input  logic i_en,
    input  sym_t i_sym,
    input  logic i_sym_stb,
    input  logic [$clog2(FRAME_LEN)-1:0] i_step,
    output decision_t o_dec,
    output logic [$clog2(FRAME_LEN)-1:0] o_wr_step,
    output logic o_wr_stb
);

    pmetric_t pm [NUM_STATES];
    pmetric_t pm_nxt [NUM_STATES];
    decision_t dec_nxt;

    // hamming distance to the symbol of transition s --u-->
    function automatic logic [1:0] branch_metric(input sym_t rx, input tstate_t s, input logic u);
        logic [2:0] win;
        sym_t exp_sym;
        win = {u, s};
        exp_sym = {^(win & GEN_A), ^(win & GEN_B)};
        return {1'b0, rx[1] ^ exp_sym[1]} + {1'b0, rx[0] ^ exp_sym[0]};
    endfunction

    function automatic pmetric_t sat_add(input pmetric_t pm_in, input logic [1:0] bm);
        logic [6:0] sum;
        sum = {1'b0, pm_in} + {5'd0, bm};
        return sum[6] ? PM_MAX : sum[5:0];
    endfunction

    always_comb
    begin
        tstate_t nst;
        tstate_t p_lo;
        tstate_t p_hi;
        pmetric_t m_lo;
        pmetric_t m_hi;
        for (int s = 0; s < NUM_STATES; s++)
        begin
            nst = tstate_t'(s);
            p_lo = {nst[0], 1'b0};
            p_hi = {nst[0], 1'b1};
            m_lo = sat_add(pm[p_lo], branch_metric(i_sym, p_lo, nst[1]));
            m_hi = sat_add(pm[p_hi], branch_metric(i_sym, p_hi, nst[1]));
            dec_nxt[s] = (m_hi < m_lo);                 // tie keeps lower
            pm_nxt[s] = (m_hi < m_lo) ? m_hi : m_lo;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en)
        begin
            for (int s = 0; s < NUM_STATES; s++)
                pm[s] <= (s == 0) ? pmetric_t'(0) : PM_MAX;  // start in state 0
            o_wr_stb <= 1'b0;
        end
        else
        begin
            o_wr_stb <= i_sym_stb;
            if (i_sym_stb)
            begin
                pm <= pm_nxt;
                o_dec <= dec_nxt;
                o_wr_step <= i_step;
            end
        end
    end

endmodule

// File: hw/codec_control.sv
`timescale 1ns/100ps

module codec_control
    import viterbi_pkg::*;
#(
    parameter int MEM_DELAY = 5
)
(
    input  logic clk,
    input  logic rst,
    input  logic i_en,
    input  logic i_mode_sel,
    input  logic i_sync,
    input  logic i_tb_done,
    output logic o_en_enc,
    output logic o_en_slice,
    output logic o_en_acs,
    output logic o_en_mem,
    output logic o_en_tb,
    output logic o_busy
);

    localparam int CNT_W = $clog2(MEM_DELAY + 1);

    ctrl_state_t state, nxt_state;
    logic [CNT_W-1:0] delay_cnt;
    logic [4:0] en_vec;     // enc, slice, acs, mem, tb

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state <= ST_IDLE;
            delay_cnt <= '0;
        end
        else
        begin
            state <= nxt_state;
            if (state == ST_MEMWAIT)
                delay_cnt <= delay_cnt + 1'b1;
            else
                delay_cnt <= '0;
        end
    end

    always_comb
    begin
        nxt_state = state;
        en_vec = 5'b00000;
        case (state)
            ST_IDLE:    nxt_state = (i_mode_sel == MODE_ENCODE) ? ST_ENCODE : ST_SLICE;
            ST_ENCODE:  en_vec = 5'b10000;
            ST_SLICE:
            begin
                en_vec = 5'b01000;
                nxt_state = ST_METRIC;
            end
            ST_METRIC:
            begin
                en_vec = 5'b01100;
                nxt_state = ST_TRELLIS;
            end
            ST_TRELLIS:
            begin
                en_vec = 5'b01110;
                if (i_sync)
                    nxt_state = ST_FLUSH;
            end
            ST_FLUSH:
            begin
                en_vec = 5'b00110;  // last decision still being written
                nxt_state = ST_MEMWAIT;
            end
            ST_MEMWAIT:
            begin
                en_vec = 5'b00010;
                if (delay_cnt == CNT_W'(MEM_DELAY - 1))
                    nxt_state = ST_TRACE;
            end
            ST_TRACE:
            begin
                en_vec = 5'b00011;
                if (i_tb_done)
                    nxt_state = ST_IDLE;
            end
            default:    nxt_state = ST_IDLE;
        endcase
        if (!i_en)
            nxt_state = ST_IDLE;
    end

    assign {o_en_enc, o_en_slice, o_en_acs, o_en_mem, o_en_tb} = i_en ? en_vec : 5'b00000;
    assign o_busy = (state != ST_IDLE);

    a_enc_tb_excl: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({o_en_enc, o_en_tb}));

endmodule

// File: hw/conv_encoder.sv
`timescale 1ns/100ps

module conv_encoder
    import viterbi_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic i_en,
    input  logic i_bit,
    input  logic i_bit_stb,
    output sym_t o_sym,
    output logic o_sym_stb
);

    tstate_t sr;            // two previous input bits
    logic [2:0] win;

    assign win = {i_bit, sr};

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en)
        begin
            sr <= '0;
            o_sym_stb <= 1'b0;
        end
        else
        begin
            o_sym_stb <= i_bit_stb;
            if (i_bit_stb)
            begin
                sr <= {i_bit, sr[1]};
                o_sym <= {^(win & GEN_A), ^(win & GEN_B)};
            end
        end
    end

endmodule

// File: hw/survivor_mem.sv
`timescale 1ns/100ps

module survivor_mem
    import viterbi_pkg::*;
#(
    parameter int FRAME_LEN = 16
)
(
    input  logic clk,
    input  logic i_en,
    input  logic i_wr_stb,
    input  logic [$clog2(FRAME_LEN)-1:0] i_wr_step,
    input  decision_t i_dec,
    input  logic [$clog2(FRAME_LEN)-1:0] i_rd_addr,
    output decision_t o_rd_dec
);

    decision_t mem [FRAME_LEN];     // one entry per trellis step

    always_ff @(posedge clk)
    begin
        if (i_en)
        begin
            if (i_wr_stb)
                mem[i_wr_step] <= i_dec;
            o_rd_dec <= mem[i_rd_addr];
        end
    end

    a_wr_in_range: assert property (@(posedge clk)
        (i_en && i_wr_stb) |-> (i_wr_step < FRAME_LEN));

endmodule

// File: hw/symbol_slicer.sv
`timescale 1ns/100ps

module symbol_slicer
    import viterbi_pkg::*;
#(
    parameter int FRAME_LEN = 16
)
(
    input  logic clk,
    input  logic rst,
    input  logic i_en,
    input  sym_t i_sym,
    input  logic i_sym_stb,
    output sym_t o_sym,
    output logic o_sym_stb,
    output logic [$clog2(FRAME_LEN)-1:0] o_step,
    output logic o_sync
);

    localparam int STEP_W = $clog2(FRAME_LEN);

    logic [STEP_W-1:0] cnt;
    logic done;             // full frame received
    logic accept;

    assign accept = i_sym_stb && !done;

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en)
        begin
            cnt <= '0;
            done <= 1'b0;
            o_sym_stb <= 1'b0;
            o_sync <= 1'b0;
        end
        else
        begin
            o_sym_stb <= accept;
            o_sync <= accept && (cnt == STEP_W'(FRAME_LEN - 1));
            if (accept)
            begin
                o_sym <= i_sym;
                o_step <= cnt;
                cnt <= cnt + 1'b1;
                if (cnt == STEP_W'(FRAME_LEN - 1))
                    done <= 1'b1;
            end
        end
    end

    a_no_extra_sym: assert property (@(posedge clk) disable iff (!rst)
        (i_en && done) |-> !i_sym_stb);

endmodule

// File: hw/traceback.sv
`timescale 1ns/100ps

module traceback
    import viterbi_pkg::*;
#(
    parameter int FRAME_LEN = 16,
    parameter int DATA_BITS = FRAME_LEN - 2
)
(
    input  logic clk,
    input  logic rst,
    input  logic i_en,
    input  decision_t i_rd_dec,
    output logic [$clog2(FRAME_LEN)-1:0] o_rd_addr,
    output logic [DATA_BITS-1:0] o_dec_word,
    output logic o_dec_stb,
    output logic o_done
);

    localparam int STEP_W = $clog2(FRAME_LEN);

    logic [STEP_W-1:0] rd_step;     // step of the decision now on i_rd_dec
    logic issuing;
    logic rd_vld;
    tstate_t st;

    always_ff @(posedge clk)
    begin
        if (!rst || !i_en)
        begin
            o_rd_addr <= STEP_W'(FRAME_LEN - 1);
            issuing <= 1'b1;
            rd_vld <= 1'b0;
            st <= '0;               // tail bits leave encoder in state 0
            o_dec_stb <= 1'b0;
            o_done <= 1'b0;
        end
        else
        begin
            rd_vld <= issuing;
            rd_step <= o_rd_addr;
            if (issuing)
            begin
                if (o_rd_addr == '0)
                    issuing <= 1'b0;
                else
                    o_rd_addr <= o_rd_addr - 1'b1;
            end
            o_dec_stb <= 1'b0;
            o_done <= 1'b0;
            if (rd_vld)
            begin
                st <= {st[0], i_rd_dec[st]};
                if (rd_step < DATA_BITS)
                    o_dec_word[rd_step] <= st[1];   // bit k = data bit of step k
                if (rd_step == '0)
                begin
                    o_dec_stb <= 1'b1;
                    o_done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/viterbi_codec_top.sv
`timescale 1ns/100ps

module viterbi_codec_top
    import viterbi_pkg::*;
#(
    parameter int FRAME_LEN = 16,
    parameter int DATA_BITS = FRAME_LEN - 2,
    parameter int MEM_DELAY = 5
)
(
    input  logic clk,
    input  logic rst,
    input  logic i_en,
    input  logic i_mode_sel,
    input  logic i_bit,
    input  logic i_bit_stb,
    input  sym_t i_sym,
    input  logic i_sym_stb,
    output sym_t o_sym,
    output logic o_sym_stb,
    output logic [DATA_BITS-1:0] o_dec_word,
    output logic o_dec_stb,
    output logic o_busy
);

    localparam int STEP_W = $clog2(FRAME_LEN);

    logic en_enc, en_slice, en_acs, en_mem, en_tb;
    logic sync, tb_done;
    sym_t sl_sym;
    logic sl_sym_stb;
    logic [STEP_W-1:0] sl_step;
    decision_t acs_dec;
    logic [STEP_W-1:0] acs_wr_step;
    logic acs_wr_stb;
    logic [STEP_W-1:0] rd_addr;
    decision_t rd_dec;

    codec_control #(.MEM_DELAY(MEM_DELAY)) ctrl_i (
        .clk(clk), .rst(rst), .i_en(i_en), .i_mode_sel(i_mode_sel),
        .i_sync(sync), .i_tb_done(tb_done),
        .o_en_enc(en_enc), .o_en_slice(en_slice), .o_en_acs(en_acs),
        .o_en_mem(en_mem), .o_en_tb(en_tb), .o_busy(o_busy)
    );

    conv_encoder enc_i (
        .clk(clk), .rst(rst), .i_en(en_enc), .i_bit(i_bit), .i_bit_stb(i_bit_stb),
        .o_sym(o_sym), .o_sym_stb(o_sym_stb)
    );

    symbol_slicer #(.FRAME_LEN(FRAME_LEN)) slice_i (
        .clk(clk), .rst(rst), .i_en(en_slice), .i_sym(i_sym), .i_sym_stb(i_sym_stb),
        .o_sym(sl_sym), .o_sym_stb(sl_sym_stb), .o_step(sl_step), .o_sync(sync)
    );

    acs_unit #(.FRAME_LEN(FRAME_LEN)) acs_i (
        .clk(clk), .rst(rst), .i_en(en_acs), .i_sym(sl_sym), .i_sym_stb(sl_sym_stb),
        .i_step(sl_step), .o_dec(acs_dec), .o_wr_step(acs_wr_step), .o_wr_stb(acs_wr_stb)
    );

    survivor_mem #(.FRAME_LEN(FRAME_LEN)) mem_i (
        .clk(clk), .i_en(en_mem), .i_wr_stb(acs_wr_stb), .i_wr_step(acs_wr_step),
        .i_dec(acs_dec), .i_rd_addr(rd_addr), .o_rd_dec(rd_dec)
    );

    traceback #(.FRAME_LEN(FRAME_LEN), .DATA_BITS(DATA_BITS)) tb_i (
        .clk(clk), .rst(rst), .i_en(en_tb), .i_rd_dec(rd_dec), .o_rd_addr(rd_addr),
        .o_dec_word(o_dec_word), .o_dec_stb(o_dec_stb), .o_done(tb_done)
    );

endmodule

// File: hw/viterbi_pkg.sv
package viterbi_pkg;

    localparam logic MODE_DECODE = 1'b0;
    localparam logic MODE_ENCODE = 1'b1;

    localparam logic [2:0] GEN_A = 3'o7;        // drives upper symbol bit
    localparam logic [2:0] GEN_B = 3'o5;

    localparam int NUM_STATES = 4;

    typedef logic [1:0] sym_t;
    typedef logic [1:0] tstate_t;               // newest input bit on top
    typedef logic [5:0] pmetric_t;
    typedef logic [NUM_STATES-1:0] decision_t;  // 1 = upper predecessor

    localparam pmetric_t PM_MAX = 6'h3f;        // saturation value

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ENCODE,
        ST_SLICE,
        ST_METRIC,
        ST_TRELLIS,
        ST_FLUSH,
        ST_MEMWAIT,
        ST_TRACE
    } ctrl_state_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the Viterbi codec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_viterbi \
    -f src.f --Mdir obj_dir -o tb_viterbi_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/tb_viterbi_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
exit 1

// File: src.f
hw/viterbi_pkg.sv
hw/codec_control.sv
hw/conv_encoder.sv
hw/symbol_slicer.sv
hw/acs_unit.sv
hw/survivor_mem.sv
hw/traceback.sv
hw/viterbi_codec_top.sv
testbench/tb_checker.sv
testbench/tb_viterbi.sv

// File: testbench/tb_checker.sv
`timescale 1ns/100ps

module tb_checker
    import viterbi_pkg::*;
#(
    parameter int DATA_BITS = 14
)
(
    input  logic clk,
    input  logic rst,
    input  logic i_bit_stb,
    input  sym_t i_sym,
    input  logic i_sym_stb,
    input  logic [DATA_BITS-1:0] i_dec_word,
    input  logic i_dec_stb,
    input  logic i_busy
);

    sym_t sym_q[$];                     // filled by tb_viterbi
    logic [DATA_BITS-1:0] word_q[$];
    string test_name = "none";
    logic quiet = 1'b0;                 // outputs must stay low
    int err_cnt = 0;

    logic bit_stb_d;
    sym_t exp_sym;
    logic [DATA_BITS-1:0] exp_word;

    always @(posedge clk)
    begin
        if (!rst)
            bit_stb_d <= 1'b0;
        else
        begin
            bit_stb_d <= i_bit_stb;
            // symbol is due exactly one cycle after its input strobe
            if (i_sym_stb !== bit_stb_d)
            begin
                err_cnt++;
                $display("Error %s: o_sym_stb expected %b, actual %b",
                         test_name, bit_stb_d, i_sym_stb);
            end
            if (i_sym_stb === 1'b1)
            begin
                if (sym_q.size() == 0)
                begin
                    err_cnt++;
                    $display("%s: o_sym_stb fired with no symbol expected", test_name);
                end
                else
                begin
                    exp_sym = sym_q.pop_front();
                    if (i_sym !== exp_sym)
                    begin
                        err_cnt++;
                        $display("Error %s: o_sym expected %b, actual %b",
                                 test_name, exp_sym, i_sym);
                    end
                end
            end
            if (i_dec_stb === 1'b1)
            begin
                if (word_q.size() == 0)
                begin
                    err_cnt++;
                    $display("%s: o_dec_stb fired with no decoded word expected", test_name);
                end
                else
                begin
                    exp_word = word_q.pop_front();
                    if (i_dec_word !== exp_word)
                    begin
                        err_cnt++;
                        $display("Error %s: o_dec_word expected %h, actual %h",
                                 test_name, exp_word, i_dec_word);
                    end
                end
            end
            if (quiet && ({i_busy, i_sym_stb, i_dec_stb} !== 3'b000))
            begin
                err_cnt++;
                $display("Error %s: busy/sym_stb/dec_stb expected 000, actual %b%b%b",
                         test_name, i_busy, i_sym_stb, i_dec_stb);
            end
        end
    end

endmodule

// File: testbench/tb_viterbi.sv
`timescale 1ns/100ps

module tb_viterbi
    import viterbi_pkg::*;
();

    localparam int FRAME_LEN = 16;
    localparam int DATA_BITS = FRAME_LEN - 2;
    localparam int MEM_DELAY = 5;
    localparam int ENC_BITS = 20;

    logic clk;
    logic rst;
    logic en;
    logic mode_sel;
    logic bit_val;
    logic bit_stb;
    sym_t sym_in;
    logic sym_stb;
    sym_t sym_out;
    logic sym_out_stb;
    logic [DATA_BITS-1:0] dec_word;
    logic dec_stb;
    logic busy;

    logic [31:0] seed;
    int tmo_cnt;

    // stimulus table, one entry per test
    string row_name[$];
    logic row_mode[$];
    logic [31:0] row_data[$];
    logic [31:0] row_mask[$];   // bit 2k+1 flips upper bit of symbol k
    int row_gap[$];
    logic row_rnd[$];           // lcg data merged with row_data

    viterbi_codec_top #(
        .FRAME_LEN(FRAME_LEN),
        .DATA_BITS(DATA_BITS),
        .MEM_DELAY(MEM_DELAY)
    ) dut_i (
        .clk(clk), .rst(rst), .i_en(en), .i_mode_sel(mode_sel),
        .i_bit(bit_val), .i_bit_stb(bit_stb), .i_sym(sym_in), .i_sym_stb(sym_stb),
        .o_sym(sym_out), .o_sym_stb(sym_out_stb), .o_dec_word(dec_word),
        .o_dec_stb(dec_stb), .o_busy(busy)
    );

    tb_checker #(.DATA_BITS(DATA_BITS)) chk_i (
        .clk(clk), .rst(rst), .i_bit_stb(bit_stb), .i_sym(sym_out),
        .i_sym_stb(sym_out_stb), .i_dec_word(dec_word), .i_dec_stb(dec_stb),
        .i_busy(busy)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // generator parities over {new bit, previous bit, oldest bit}
    function automatic sym_t encode_symbol(input logic [2:0] win);
        sym_t s;
        s = 2'b00;
        for (int i = 0; i < 3; i++)
        begin
            s[1] = s[1] ^ (win[i] & GEN_A[i]);
            s[0] = s[0] ^ (win[i] & GEN_B[i]);
        end
        return s;
    endfunction

    task automatic add_row(input string name, input logic mode, input logic [31:0] data,
                           input logic [31:0] mask, input int gap, input logic rnd);
        row_name.push_back(name);
        row_mode.push_back(mode);
        row_data.push_back(data);
        row_mask.push_back(mask);
        row_gap.push_back(gap);
        row_rnd.push_back(rnd);
    endtask

    // back through idle so the mode is sampled again
    task automatic restart_session(input logic mode);
        @(negedge clk);
        en = 1'b0;
        bit_stb = 1'b0;
        sym_stb = 1'b0;
        repeat (2) @(negedge clk);
        mode_sel = mode;
        en = 1'b1;
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        for (n = 0; n < limit; n++)
        begin
            @(negedge clk);
            if (busy === level)
                break;
        end
        if (n == limit)
        begin
            tmo_cnt++;
            $display("Timeout in %s: o_busy did not go to %b within %0d cycles",
                     chk_i.test_name, level, limit);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while ((chk_i.sym_q.size() + chk_i.word_q.size()) > 0 && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if ((chk_i.sym_q.size() + chk_i.word_q.size()) > 0)
        begin
            tmo_cnt++;
            $display("Timeout in %s: %0d expected outputs never arrived", chk_i.test_name,
                     chk_i.sym_q.size() + chk_i.word_q.size());
            chk_i.sym_q.delete();
            chk_i.word_q.delete();
        end
    endtask

    task automatic run_encode(input logic [31:0] data);
        logic [1:0] hist;
        int gap;
        hist = 2'b00;           // fresh session starts in state 0
        wait_busy(1'b1, 10);
        for (int k = 0; k < ENC_BITS; k++)
        begin
            seed = lcg_next(seed);
            gap = int'(seed[17:16]);
            repeat (gap)
            begin
                bit_stb = 1'b0;
                @(negedge clk);
            end
            bit_val = data[k];
            bit_stb = 1'b1;
            chk_i.sym_q.push_back(encode_symbol({data[k], hist}));
            hist = {data[k], hist[1]};
            @(negedge clk);
        end
        bit_stb = 1'b0;
        wait_drain(20);
    endtask

    task automatic run_decode(input logic [31:0] data, input logic [31:0] mask,
                              input int gap);
        logic [1:0] hist;
        logic b;
        hist = 2'b00;
        wait_busy(1'b1, 10);
        chk_i.word_q.push_back(data[DATA_BITS-1:0]);
        for (int k = 0; k < FRAME_LEN; k++)
        begin
            repeat (gap)
            begin
                sym_stb = 1'b0;
                @(negedge clk);
            end
            b = (k < DATA_BITS) ? data[k] : 1'b0;   // zero tail
            sym_in = encode_symbol({b, hist}) ^ {mask[2*k+1], mask[2*k]};
            sym_stb = 1'b1;
            hist = {b, hist[1]};
            @(negedge clk);
        end
        sym_stb = 1'b0;
        wait_busy(1'b0, 40 + MEM_DELAY + 2 * FRAME_LEN);
        wait_drain(10);
    endtask

    initial
    begin
        logic [31:0] data;
        clk = 1'b0;
        rst = 1'b0;
        en = 1'b0;
        mode_sel = MODE_DECODE;
        bit_val = 1'b0;
        bit_stb = 1'b0;
        sym_in = 2'b00;
        sym_stb = 1'b0;
        seed = 32'h8df8;
        tmo_cnt = 0;

        add_row("enc_lcg_a", MODE_ENCODE, 32'h0008_0000, 32'h0, 0, 1'b1);  // ends off state 0
        add_row("enc_lcg_b", MODE_ENCODE, 32'h0, 32'h0, 0, 1'b1);
        add_row("dec_zeros", MODE_DECODE, 32'h0000, 32'h0, 0, 1'b0);
        add_row("dec_ones", MODE_DECODE, 32'h3fff, 32'h0, 1, 1'b0);
        add_row("dec_alt", MODE_DECODE, 32'h1555, 32'h0, 2, 1'b0);
        add_row("dec_lcg", MODE_DECODE, 32'h0, 32'h0, 1, 1'b1);
        add_row("dec_err_first", MODE_DECODE, 32'h2b6d, 32'h0000_0002, 0, 1'b0);
        add_row("dec_err_mid", MODE_DECODE, 32'h2b6d, 32'h0000_4000, 0, 1'b0);
        add_row("dec_err_last", MODE_DECODE, 32'h2b6d, 32'h0400_0000, 0, 1'b0);
        add_row("dec_err_two", MODE_DECODE, 32'h0f0f, 32'h0010_0008, 1, 1'b0);
        add_row("dec_err_two_lcg", MODE_DECODE, 32'h0, 32'h0100_0020, 0, 1'b1);
        add_row("b2b_fast_a", MODE_DECODE, 32'h0, 32'h0, 0, 1'b1);
        add_row("b2b_fast_b", MODE_DECODE, 32'h0, 32'h0, 0, 1'b1);
        add_row("b2b_slow_a", MODE_DECODE, 32'h0, 32'h0, 7, 1'b1);
        add_row("b2b_slow_b", MODE_DECODE, 32'h0, 32'h0, 11, 1'b1);

        repeat (10) @(negedge clk);
        rst = 1'b1;

        chk_i.test_name = "idle_after_reset";
        chk_i.quiet = 1'b1;
        repeat (20) @(negedge clk);
        chk_i.quiet = 1'b0;

        for (int r = 0; r < row_name.size(); r++)
        begin
            data = row_data[r];
            if (row_rnd[r])
            begin
                seed = lcg_next(seed);
                data = row_data[r] | {8'h00, seed[31:8]};
            end
            chk_i.test_name = row_name[r];
            // decode frames follow each other without leaving enable
            if (row_mode[r] == MODE_ENCODE || row_mode[r] != mode_sel || !en)
                restart_session(row_mode[r]);
            if (row_mode[r] == MODE_ENCODE)
                run_encode(data);
            else
                run_decode(data, row_mask[r], row_gap[r]);
        end

        repeat (4) @(negedge clk);
        en = 1'b0;
        repeat (2) @(negedge clk);

        $display("errors: %0d  timeouts: %0d", chk_i.err_cnt, tmo_cnt);
        if (chk_i.err_cnt == 0 && tmo_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
